//--- verilog/redmule_ce_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants for the FP16 compare element.
// Only binary16 is supported. There is no format parameter.
// NUM_PIPE_REGS may be set from 1 to 4. Latency follows it one to one.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package redmule_ce_pkg;

  localparam int unsigned FP16_EXP_W = 5;
  localparam int unsigned FP16_MAN_W = 10;
  localparam int unsigned FP16_W     = 1 + FP16_EXP_W + FP16_MAN_W;

  localparam int unsigned NUM_PIPE_REGS = 2; // slots between stage 1 and stage 2.

  typedef logic [FP16_W-1:0]     fp16_t;
  typedef logic [FP16_EXP_W-1:0] fp16_exp_t;
  typedef logic [FP16_MAN_W-1:0] fp16_man_t;

  localparam fp16_t FP16_QNAN = 16'h7E00; // positive, only the quiet bit set.

  typedef enum logic {
    OP_MIN = 1'b0,
    OP_MAX = 1'b1
  } minmax_op_e;

  typedef enum logic [1:0] {
    S2_BYPASS = 2'd0, // stage-1 result goes straight to the output.
    S2_MIN    = 2'd1,
    S2_MAX    = 2'd2
  } stage2_op_e;

  typedef struct packed {
    fp16_t      x;
    fp16_t      w;
    fp16_t      bias;
    minmax_op_e op1;
    stage2_op_e op2;
  } ce_req_t;

  typedef struct packed {
    fp16_t      s1_res;
    fp16_t      bias;       // bias travels with its own request.
    stage2_op_e op2;
    logic       s1_invalid;
  } ce_pipe_word_t;

  typedef struct packed {
    fp16_t z;
    logic  invalid;
  } ce_result_t;

endpackage

//--- verilog/fp16_minmax.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational FP16 minNum/maxNum with zero latency.
// Minus zero orders below plus zero. A single NaN operand is ignored,
// two NaNs give the canonical quiet NaN. Any signalling NaN input
// raises invalid_o, whatever the result. Subnormals compare as is.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fp16_minmax import redmule_ce_pkg::*; (
  input  fp16_t      a_i,
  input  fp16_t      b_i,
  input  minmax_op_e op_i,
  output fp16_t      res_o,
  output logic       invalid_o
);

  fp16_exp_t a_exp;
  fp16_exp_t b_exp;
  fp16_man_t a_man;
  fp16_man_t b_man;
  logic      a_nan;
  logic      b_nan;
  logic      a_snan;
  logic      b_snan;
  logic      a_lt_b;

  assign a_exp = a_i[FP16_MAN_W +: FP16_EXP_W];
  assign b_exp = b_i[FP16_MAN_W +: FP16_EXP_W];
  assign a_man = a_i[FP16_MAN_W-1:0];
  assign b_man = b_i[FP16_MAN_W-1:0];

  assign a_nan  = (&a_exp) & (|a_man);
  assign b_nan  = (&b_exp) & (|b_man);
  assign a_snan = a_nan & ~a_man[FP16_MAN_W-1]; // quiet bit clear means signalling.
  assign b_snan = b_nan & ~b_man[FP16_MAN_W-1];

  // Sign-magnitude ordering, so -0 sits just below +0.
  always_comb begin
    if (a_i[FP16_W-1] != b_i[FP16_W-1]) begin
      a_lt_b = a_i[FP16_W-1]; // the negative one is smaller.
    end else if (a_i[FP16_W-1]) begin
      a_lt_b = a_i[FP16_W-2:0] > b_i[FP16_W-2:0]; // larger magnitude is lower.
    end else begin
      a_lt_b = a_i[FP16_W-2:0] < b_i[FP16_W-2:0];
    end
  end

  always_comb begin
    if (a_nan && b_nan) begin
      res_o = FP16_QNAN;
    end else if (a_nan) begin
      res_o = b_i;
    end else if (b_nan) begin
      res_o = a_i;
    end else if (op_i == OP_MIN) begin
      res_o = a_lt_b ? a_i : b_i;
    end else begin
      res_o = a_lt_b ? b_i : a_i;
    end
  end

  assign invalid_o = a_snan | b_snan;

endmodule

//--- verilog/ce_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lockstep pipeline of NUM_PIPE_REGS slots with valid/ready handshake.
// All slots move together when the last slot is empty or the sink is
// ready, so a bubble is only absorbed at the tail. A flush drops every
// word in flight plus any request offered in the same cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ce_pipe import redmule_ce_pkg::*; (
  input  logic          stage2_noncomp_input_pipe_clk,
  input  logic          rst_ni,
  input  logic          flush_i,
  input  logic          in_valid_i,
  input  ce_pipe_word_t in_word_i,
  input  logic          out_ready_i,
  output logic          in_ready_o,
  output logic          out_valid_o,
  output ce_pipe_word_t out_word_o,
  output logic          busy_o
);

  logic [NUM_PIPE_REGS-1:0] valid_q;
  logic [NUM_PIPE_REGS-1:0] valid_in;
  ce_pipe_word_t            word_q  [NUM_PIPE_REGS];
  ce_pipe_word_t            word_in [NUM_PIPE_REGS];
  logic                     advance;

  assign advance = ~valid_q[NUM_PIPE_REGS-1] | out_ready_i;

  // Each slot takes the value of the slot in front of it.
  always_comb begin
    valid_in[0] = in_valid_i;
    word_in[0]  = in_word_i;
    for (int i = 1; i < NUM_PIPE_REGS; i++) begin
      valid_in[i] = valid_q[i-1];
      word_in[i]  = word_q[i-1];
    end
  end

  always_ff @(posedge stage2_noncomp_input_pipe_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0; // everything in flight is dropped.
    end else if (advance) begin
      valid_q <= valid_in;
    end
  end

  always_ff @(posedge stage2_noncomp_input_pipe_clk) begin
    if (advance) begin
      word_q <= word_in;
    end
  end

  assign in_ready_o  = advance;
  assign out_valid_o = valid_q[NUM_PIPE_REGS-1];
  assign out_word_o  = word_q[NUM_PIPE_REGS-1];
  assign busy_o      = |valid_q;

  // A stalled output word must not change until it is taken.
  a_out_stable: assert property (
    @(posedge stage2_noncomp_input_pipe_clk) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> $stable(out_word_o)
  );

  a_flush_empties: assert property (
    @(posedge stage2_noncomp_input_pipe_clk) disable iff (!rst_ni)
    flush_i |=> (valid_q == '0)
  );

endmodule

//--- verilog/ce_stage2.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Second compare stage, purely combinational.
// Compares the stage-1 result against the bias carried in the same
// pipeline word, or bypasses it. The invalid flag of stage 1 is kept
// in both cases.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ce_stage2 import redmule_ce_pkg::*; (
  input  ce_pipe_word_t word_i,
  output ce_result_t    res_o
);

  minmax_op_e s2_op;
  fp16_t      s2_res;
  logic       s2_invalid;

  assign s2_op = (word_i.op2 == S2_MAX) ? OP_MAX : OP_MIN;

  fp16_minmax s2_minmax_i (
    .a_i       ( word_i.s1_res ),
    .b_i       ( word_i.bias   ),
    .op_i      ( s2_op         ),
    .res_o     ( s2_res        ),
    .invalid_o ( s2_invalid    )
  );

  always_comb begin
    if (word_i.op2 == S2_BYPASS) begin
      res_o.z       = word_i.s1_res;
      res_o.invalid = word_i.s1_invalid; // a bias sNaN is not looked at here.
    end else begin
      res_o.z       = s2_res;
      res_o.invalid = word_i.s1_invalid | s2_invalid;
    end
  end

endmodule

//--- verilog/redmule_ce.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FP16 compare element: min/max of x and w, then an optional min/max
// against the bias. Latency is NUM_PIPE_REGS cycles without stalls.
// Results leave in acceptance order. flush_i drops all work in flight.
// One clock domain, no clock gating.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module redmule_ce import redmule_ce_pkg::*; (
  input  logic       stage2_noncomp_input_pipe_clk,
  input  logic       rst_ni,
  input  ce_req_t    req_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  output ce_result_t res_o,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  input  logic       flush_i,
  output logic       busy_o
);

  fp16_t         s1_res;
  logic          s1_invalid;
  ce_pipe_word_t s1_word;
  ce_pipe_word_t s2_word;

  fp16_minmax s1_minmax_i (
    .a_i       ( req_i.x    ),
    .b_i       ( req_i.w    ),
    .op_i      ( req_i.op1  ),
    .res_o     ( s1_res     ),
    .invalid_o ( s1_invalid )
  );

  assign s1_word = '{s1_res: s1_res, bias: req_i.bias, op2: req_i.op2,
                     s1_invalid: s1_invalid}; // bias stays paired with its request.

  ce_pipe ce_pipe_i (
    .stage2_noncomp_input_pipe_clk ( stage2_noncomp_input_pipe_clk ),
    .rst_ni                        ( rst_ni                        ),
    .flush_i                       ( flush_i                       ),
    .in_valid_i                    ( in_valid_i                    ),
    .in_word_i                     ( s1_word                       ),
    .out_ready_i                   ( out_ready_i                   ),
    .in_ready_o                    ( in_ready_o                    ),
    .out_valid_o                   ( out_valid_o                   ),
    .out_word_o                    ( s2_word                       ),
    .busy_o                        ( busy_o                        )
  );

  ce_stage2 ce_stage2_i (
    .word_i ( s2_word ),
    .res_o  ( res_o   )
  );

  a_no_valid_in_reset: assert property (
    @(posedge stage2_noncomp_input_pipe_clk) !rst_ni |-> !out_valid_o
  );

endmodule

//--- verif/redmule_ce_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the FP16 compare element.
// Patterns are read from verif/ce_patterns.hex with seven hex columns
// per pattern, so the simulation has to start in the project root.
// Latency is checked only while out_ready_i is held high. Outputs are
// sampled on the falling edge, where every DUT signal is settled.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module redmule_ce_tb import redmule_ce_pkg::*; ();

  localparam int NUM_PAT        = 32;
  localparam int COLS           = 7;
  localparam int TIMEOUT_CYCLES = 8 * (2 * NUM_PAT + 2) + 200; // two passes plus the flush pair.

  logic       stage2_noncomp_input_pipe_clk;
  logic       rst_ni;
  ce_req_t    req_i;
  logic       in_valid_i;
  logic       in_ready_o;
  ce_result_t res_o;
  logic       out_valid_o;
  logic       out_ready_i;
  logic       flush_i;
  logic       busy_o;

  logic [15:0] pat_mem [NUM_PAT*COLS];
  ce_result_t  exp_q [$];
  int          acc_q [$];   // cycle in which each request was accepted.
  int          idx_q [$];
  int          cycle = 0;
  int          errors;
  int          checks;
  int          cur_idx;     // pattern currently offered on req_i.
  logic        lat_check;
  logic        random_ready;
  logic        ready_level;
  logic [31:0] rng_state;
  logic        held_valid;  // a stalled result was seen on the last falling edge.
  ce_result_t  held_res;

  redmule_ce redmule_ce_i (
    .stage2_noncomp_input_pipe_clk ( stage2_noncomp_input_pipe_clk ),
    .rst_ni                        ( rst_ni                        ),
    .req_i                         ( req_i                         ),
    .in_valid_i                    ( in_valid_i                    ),
    .in_ready_o                    ( in_ready_o                    ),
    .res_o                         ( res_o                         ),
    .out_valid_o                   ( out_valid_o                   ),
    .out_ready_i                   ( out_ready_i                   ),
    .flush_i                       ( flush_i                       ),
    .busy_o                        ( busy_o                        )
  );

  initial begin
    stage2_noncomp_input_pipe_clk = 1'b0;
    forever #2 stage2_noncomp_input_pipe_clk = ~stage2_noncomp_input_pipe_clk;
  end

  always @(posedge stage2_noncomp_input_pipe_clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic ce_result_t expected_of(input int idx);
    ce_result_t r;
    r.z       = pat_mem[idx*COLS + 5];
    r.invalid = pat_mem[idx*COLS + 6][0];
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  // Offers one pattern and holds it until the DUT takes it.
  task automatic send_pattern(input int idx);
    logic accepted;
    req_i.x    = pat_mem[idx*COLS + 0];
    req_i.w    = pat_mem[idx*COLS + 1];
    req_i.bias = pat_mem[idx*COLS + 2];
    req_i.op1  = minmax_op_e'(pat_mem[idx*COLS + 3][0]);
    req_i.op2  = stage2_op_e'(pat_mem[idx*COLS + 4][1:0]);
    cur_idx    = idx;
    in_valid_i = 1'b1;
    accepted   = 1'b0;
    while (!accepted) begin
      @(negedge stage2_noncomp_input_pipe_clk);
      accepted = in_ready_o; // transfer happens on the coming rising edge.
      @(posedge stage2_noncomp_input_pipe_clk);
      #1;
    end
  endtask

  task automatic set_ready(input logic use_random, input logic level);
    @(negedge stage2_noncomp_input_pipe_clk);
    random_ready = use_random;
    ready_level  = level;
    @(posedge stage2_noncomp_input_pipe_clk);
    #1;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge stage2_noncomp_input_pipe_clk);
    end
    @(posedge stage2_noncomp_input_pipe_clk);
    #1;
  endtask

  task automatic take_output();
    ce_result_t exp_res;
    int         idx;
    int         acc;
    if (exp_q.size() == 0) begin
      errors++;
      $display("unexpected output 0x%0h with no request waiting for it", res_o);
    end else begin
      exp_res = exp_q.pop_front();
      idx     = idx_q.pop_front();
      acc     = acc_q.pop_front();
      check_value($sformatf("pattern %0d z", idx), 32'(exp_res.z), 32'(res_o.z));
      check_value($sformatf("pattern %0d invalid", idx), 32'(exp_res.invalid),
                  32'(res_o.invalid));
      if (lat_check) begin
        check_value($sformatf("pattern %0d latency", idx), NUM_PIPE_REGS, cycle - acc);
      end
    end
  endtask

  always @(posedge stage2_noncomp_input_pipe_clk) begin
    #1;
    if (random_ready) begin
      rng_state   = xorshift32(rng_state);
      out_ready_i = rng_state[1:0] != 2'b00; // ready in about three cycles of four.
    end else begin
      out_ready_i = ready_level;
    end
  end

  // Scoreboard. Handshakes seen here complete on the next rising edge.
  always @(negedge stage2_noncomp_input_pipe_clk) begin
    if (rst_ni) begin
      if (held_valid) begin
        check_value("stalled out_valid", 1, 32'(out_valid_o));
        check_value("stalled res", {15'd0, held_res}, {15'd0, res_o});
      end
      held_valid = out_valid_o && !out_ready_i && !flush_i;
      held_res   = res_o;
      if (out_valid_o && out_ready_i) begin
        take_output();
      end
      if (flush_i) begin
        check_value("flush busy before", 1, 32'(busy_o)); // both requests still in flight.
        exp_q.delete();
        acc_q.delete();
        idx_q.delete();
      end else if (in_valid_i && in_ready_o) begin
        exp_q.push_back(expected_of(cur_idx));
        acc_q.push_back(cycle);
        idx_q.push_back(cur_idx);
      end
    end
  end

  initial begin
    wait (cycle >= TIMEOUT_CYCLES);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst_ni       = 1'b0;
    req_i        = '0;
    in_valid_i   = 1'b0;
    out_ready_i  = 1'b0;
    flush_i      = 1'b0;
    ready_level  = 1'b1;
    random_ready = 1'b0;
    lat_check    = 1'b0;
    rng_state    = 32'd87596;
    held_valid   = 1'b0;
    held_res     = '0;
    cur_idx      = 0;
    errors       = 0;
    checks       = 0;
    $readmemh("verif/ce_patterns.hex", pat_mem);
    repeat (16) @(posedge stage2_noncomp_input_pipe_clk);
    #1;
    rst_ni = 1'b1;
    @(negedge stage2_noncomp_input_pipe_clk);
    check_value("reset out_valid", 0, 32'(out_valid_o));
    check_value("reset busy", 0, 32'(busy_o));
    check_value("reset in_ready", 1, 32'(in_ready_o));
    @(posedge stage2_noncomp_input_pipe_clk);
    #1;

    lat_check = 1'b1; // sink always ready, so every result is on time.
    for (int i = 0; i < NUM_PAT; i++) begin
      send_pattern(i);
    end
    in_valid_i = 1'b0;
    wait_drain();
    lat_check = 1'b0;

    set_ready(1'b1, 1'b1);
    for (int i = 0; i < NUM_PAT; i++) begin
      send_pattern(i);
    end
    in_valid_i = 1'b0;
    wait_drain();

    // Two requests go in with the sink stalled, then both are flushed.
    set_ready(1'b0, 1'b0);
    send_pattern(0);
    send_pattern(1);
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(posedge stage2_noncomp_input_pipe_clk);
    #1;
    flush_i = 1'b0;
    @(negedge stage2_noncomp_input_pipe_clk);
    check_value("flush busy", 0, 32'(busy_o));
    check_value("flush out_valid", 0, 32'(out_valid_o));
    set_ready(1'b0, 1'b1);
    repeat (2 * NUM_PIPE_REGS + 2) @(posedge stage2_noncomp_input_pipe_clk);
    @(negedge stage2_noncomp_input_pipe_clk);
    check_value("flush stays idle", 0, 32'(busy_o));

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verif/ce_patterns.hex
// Columns are x w bias op1 op2 z invalid, all in hex.
// op1 is 0 for min and 1 for max. op2 is 0 bypass, 1 min, 2 max.
3C00 4000 0000 0 0 3C00 0
3C00 4000 0000 1 0 4000 0
BC00 3800 0000 0 0 BC00 0
BC00 3800 0000 1 0 3800 0
C000 BC00 0000 0 0 C000 0
C000 BC00 0000 1 0 BC00 0
8000 0000 3C00 0 0 8000 0
8000 0000 3C00 1 0 0000 0
0000 8000 3C00 0 0 8000 0
0000 8000 3C00 1 0 0000 0
FC00 7C00 0000 0 0 FC00 0
4200 4200 0000 1 0 4200 0
3C00 4000 4200 1 1 4000 0
3C00 4000 3800 1 1 3800 0
3C00 4000 4200 0 2 4200 0
BC00 C000 B800 0 2 B800 0
BC00 C000 B800 1 1 BC00 0
3800 3400 8000 0 1 8000 0
8000 3400 0000 0 2 0000 0
4400 C200 4200 1 2 4400 0
7E00 3C00 0000 0 0 3C00 0
4000 FF00 0000 1 0 4000 0
7E00 FF00 0000 0 0 7E00 0
7C01 3C00 0000 0 0 3C00 1
3C00 FD00 0000 1 0 3C00 1
7C01 7E00 0000 1 0 7E00 1
3C00 4000 7E00 1 1 4000 0
3C00 4000 7C01 0 2 3C00 1
7E00 FF00 3800 0 1 3800 0
7E00 FF00 7E00 0 2 7E00 0
FD00 FF00 4000 1 2 4000 1
7C01 FC00 C000 1 1 FC00 1

//--- tb.f
verilog/redmule_ce_pkg.sv
verilog/fp16_minmax.sv
verilog/ce_pipe.sv
verilog/ce_stage2.sv
verilog/redmule_ce.sv
verif/redmule_ce_tb.sv

//--- Makefile
# Verilator flow for the FP16 compare element. Run from the project root.
TOP := redmule_ce_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Checks failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "All checks passed" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
